/* nv12.f */
+incdir+hw
hw/nv12_video_pkg.sv
hw/nv12_apb_pkg.sv
hw/nv12_apb_regs.sv
hw/nv12_raster_ctrl.sv
hw/nv12_luma_pack.sv
hw/nv12_chroma_sub.sv
hw/nv12_top.sv
sim/nv12_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the nv12 testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module nv12_tb -f nv12.f

# Keep the output even when the simulation stops with an error
out=$(./obj_dir/Vnv12_tb || true)
echo "$out"

if echo "$out" | grep -q "^Simulation passed$"; then
    exit 0
fi
exit 1

/* sim/nv12_tb.sv */
`timescale 1ns/1ps
`include "nv12_defs.svh"

module nv12_tb;
    import nv12_video_pkg::*;
    import nv12_apb_pkg::*;

    localparam logic [31:0] SEED = 32'ha411_3b63;
    localparam int FRAMES      = 3;
    localparam int COLS        = `NV12_IMG_W / 2;
    localparam int Y_WORDS     = `NV12_Y_BYTES / 2;
    localparam int UV_WORDS    = `NV12_UV_BYTES / 2;
    localparam int LINE_BLANK  = 8;
    localparam int FRAME_BLANK = 40;
    // A CTRL write and a short lead-in come before every frame
    localparam int FRAME_CLKS  = 8 + `NV12_IMG_H * (`NV12_LINE_CLKS + LINE_BLANK) + FRAME_BLANK;
    localparam int APB_CLKS    = 64;
    localparam int TIMEOUT_NS  = 4 * (8 + APB_CLKS + FRAMES * FRAME_CLKS) * 4;

    logic        clk;
    logic        rst_n;
    logic        vsync;
    logic        hsync;
    sample_t     data;
    apb_req_t    apb;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    plane_desc_t plane;
    logic        wr_start;
    logic [15:0] y_data;
    logic        y_vld;
    logic [15:0] uv_data;
    logic        uv_vld;
    logic [1:0]  frame_idx;

    sample_t     frame_mem [FRAMES][`NV12_IMG_H][`NV12_LINE_CLKS];
    logic [31:0] bases [3] = '{32'h0000_1000, 32'h0000_2400, 32'h0000_3800};
    logic        nv21_mode [FRAMES] = '{1'b0, 1'b1, 1'b0};
    logic [31:0] reg_model [4];
    int          errors = 0;
    int          y_cnt;
    int          uv_cnt;
    int          vs_high_cnt;
    logic        vs_q;
    logic        fall_seen;
    logic [1:0]  exp_idx;
    logic [31:0] exp_base;
    logic        exp_start;
    logic        video_on;

    nv12_top u_nv12_top (
        .i_clk       (clk),
        .i_rst_n     (rst_n),
        .i_vsync     (vsync),
        .i_hsync     (hsync),
        .i_data      (data),
        .i_apb       (apb),
        .o_prdata    (prdata),
        .o_pready    (pready),
        .o_pslverr   (pslverr),
        .o_plane     (plane),
        .o_wr_start  (wr_start),
        .o_y_data    (y_data),
        .o_y_vld     (y_vld),
        .o_uv_data   (uv_data),
        .o_uv_vld    (uv_vld),
        .o_frame_idx (frame_idx)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ------------------------------
    // Reference timing model
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vs_q        <= 1'b0;
            fall_seen   <= 1'b0;
            exp_idx     <= 2'd0;
            exp_base    <= '0;
            vs_high_cnt <= 0;
        end else begin
            vs_q      <= vsync;
            fall_seen <= vs_q && !vsync;
            // Index moves one cycle after the edge that sees vsync low
            if (fall_seen) exp_idx <= (exp_idx == 2'd2) ? 2'd0 : exp_idx + 2'd1;
            exp_base  <= (exp_idx == 2'd0) ? bases[0] : (exp_idx == 2'd1) ? bases[1] : bases[2];
            if (!vsync) begin
                vs_high_cnt <= 0;
            end else if (vs_high_cnt <= `NV12_START_DELAY + `NV12_START_LEN) begin
                vs_high_cnt <= vs_high_cnt + 1;
            end
        end
    end

    // Count of edges that saw vsync high
    assign exp_start = (vs_high_cnt > `NV12_START_DELAY)
                       && (vs_high_cnt <= `NV12_START_DELAY + `NV12_START_LEN);

    // By the next rising edge the count already includes the word on the bus
    always_ff @(negedge clk or negedge rst_n) begin
        if (!rst_n) begin
            y_cnt  <= 0;
            uv_cnt <= 0;
        end else begin
            if (y_vld) y_cnt <= y_cnt + 1;
            if (uv_vld) uv_cnt <= uv_cnt + 1;
        end
    end

    // Y bytes sit at even sample positions of a line
    function automatic logic [15:0] exp_y_word(input int k);
        int f;
        int ln;
        int p;
        f  = (k / Y_WORDS) % FRAMES;
        ln = (k % Y_WORDS) / COLS;
        p  = k % COLS;
        return {frame_mem[f][ln][4*p+2], frame_mem[f][ln][4*p]};
    endfunction

    function automatic sample_t floor_avg(input sample_t a, input sample_t b);
        return sample_t'((int'(a) + int'(b)) / 2);
    endfunction

    // One word per column of each odd line, U at 4c+1 and V at 4c+3
    function automatic logic [15:0] exp_uv_word(input int k);
        int      f;
        int      pr;
        int      c;
        sample_t u;
        sample_t v;
        f  = (k / UV_WORDS) % FRAMES;
        pr = (k % UV_WORDS) / COLS;
        c  = k % COLS;
        u  = floor_avg(frame_mem[f][2*pr+1][4*c+1], frame_mem[f][2*pr][4*c+1]);
        v  = floor_avg(frame_mem[f][2*pr+1][4*c+3], frame_mem[f][2*pr][4*c+3]);
        return nv21_mode[f] ? {v, u} : {u, v};
    endfunction

    // ------------------------------
    // Checks
    // ------------------------------
    a_luma_word : assert property (@(posedge clk) disable iff (!rst_n)
        y_vld |-> y_data == exp_y_word(y_cnt - 1))
    else begin
        errors++;
        $display("Fail luma_word: expected %h actual %h", exp_y_word(y_cnt - 1), y_data);
    end

    a_chroma_word : assert property (@(posedge clk) disable iff (!rst_n)
        uv_vld |-> uv_data == exp_uv_word(uv_cnt - 1))
    else begin
        errors++;
        $display("Fail chroma_word: expected %h actual %h", exp_uv_word(uv_cnt - 1), uv_data);
    end

    // All words of a frame are out before vsync drops
    a_luma_count : assert property (@(posedge clk) disable iff (!rst_n)
        $fell(vsync) |-> y_cnt == (int'(exp_idx) + 1) * Y_WORDS)
    else begin
        errors++;
        $display("Fail luma_count: expected %0d actual %0d", (int'(exp_idx) + 1) * Y_WORDS, y_cnt);
    end

    a_chroma_count : assert property (@(posedge clk) disable iff (!rst_n)
        $fell(vsync) |-> uv_cnt == (int'(exp_idx) + 1) * UV_WORDS)
    else begin
        errors++;
        $display("Fail chroma_count: expected %0d actual %0d",
                 (int'(exp_idx) + 1) * UV_WORDS, uv_cnt);
    end

    a_frame_idx : assert property (@(posedge clk) disable iff (!rst_n)
        frame_idx == exp_idx)
    else begin
        errors++;
        $display("Fail frame_idx: expected %0d actual %0d", exp_idx, frame_idx);
    end

    a_plane_addr : assert property (@(posedge clk) disable iff (!rst_n)
        video_on |-> plane.y_addr == exp_base
                     && plane.uv_addr == exp_base + 32'(`NV12_Y_BYTES / 4))
    else begin
        errors++;
        $display("Fail plane_addr: expected %h/%h actual %h/%h", exp_base,
                 exp_base + 32'(`NV12_Y_BYTES / 4), plane.y_addr, plane.uv_addr);
    end

    // Lengths count the 16-bit words of each plane
    a_plane_len : assert property (@(posedge clk) disable iff (!rst_n)
        video_on |-> plane.y_len == 32'(Y_WORDS) && plane.uv_len == 32'(UV_WORDS))
    else begin
        errors++;
        $display("Fail plane_len: expected %0d/%0d actual %0d/%0d", Y_WORDS, UV_WORDS,
                 plane.y_len, plane.uv_len);
    end

    a_wr_start : assert property (@(posedge clk) disable iff (!rst_n)
        wr_start == exp_start)
    else begin
        errors++;
        $display("Fail wr_start: expected %b actual %b", exp_start, wr_start);
    end

    a_apb_ready : assert property (@(posedge clk) disable iff (!rst_n)
        pready)
    else begin
        errors++;
        $display("Fail apb_ready: expected 1 actual %b", pready);
    end

    a_apb_readback : assert property (@(posedge clk) disable iff (!rst_n)
        (apb.psel && apb.penable && !apb.pwrite && apb.paddr[1:0] == 2'b00)
        |-> prdata == reg_model[apb.paddr[3:2]])
    else begin
        errors++;
        $display("Fail apb_readback: expected %h actual %h", reg_model[apb.paddr[3:2]], prdata);
    end

    // Only the four word offsets are mapped
    a_apb_slverr : assert property (@(posedge clk) disable iff (!rst_n)
        pslverr == (apb.psel && apb.penable && apb.paddr[1:0] != 2'b00))
    else begin
        errors++;
        $display("Fail apb_slverr: expected %b actual %b",
                 apb.psel && apb.penable && apb.paddr[1:0] != 2'b00, pslverr);
    end

    // ------------------------------
    // Stimulus
    // ------------------------------
    task automatic apb_transfer(input logic write, input logic [3:0] addr,
                                input logic [31:0] wdata);
        @(negedge clk);
        apb.psel    = 1'b1;
        apb.penable = 1'b0;
        apb.pwrite  = write;
        apb.paddr   = addr;
        apb.pwdata  = wdata;
        @(negedge clk);
        apb.penable = 1'b1;
        @(negedge clk);
        apb = '0;
        if (write && addr[1:0] == 2'b00) begin
            reg_model[addr[3:2]] = (addr == `NV12_REG_CTRL) ? {31'd0, wdata[0]} : wdata;
        end
    endtask

    task automatic drive_frame(input int f);
        apb_transfer(1'b1, `NV12_REG_CTRL, {31'd0, nv21_mode[f]});
        vsync = 1'b1;
        repeat (4) @(negedge clk);
        for (int ln = 0; ln < `NV12_IMG_H; ln++) begin
            hsync = 1'b1;
            for (int s = 0; s < `NV12_LINE_CLKS; s++) begin
                data = frame_mem[f][ln][s];
                @(negedge clk);
            end
            hsync = 1'b0;
            data  = sample_t'($urandom);
            repeat (LINE_BLANK) @(negedge clk);
        end
        vsync = 1'b0;
        repeat (FRAME_BLANK) @(negedge clk);
    endtask

    initial begin
        void'($urandom(SEED));
        rst_n    = 1'b0;
        vsync    = 1'b0;
        hsync    = 1'b0;
        data     = '0;
        apb      = '0;
        video_on = 1'b0;
        foreach (frame_mem[f, ln, s]) frame_mem[f][ln][s] = sample_t'($urandom);
        foreach (reg_model[i]) reg_model[i] = '0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;

        // Reset values, then write and read back each register
        for (int i = 0; i < 4; i++) apb_transfer(1'b0, 4'(4 * i), '0);
        for (int i = 0; i < 3; i++) begin
            apb_transfer(1'b1, 4'(4 * i), bases[i]);
            apb_transfer(1'b0, 4'(4 * i), '0);
        end
        apb_transfer(1'b1, `NV12_REG_CTRL, 32'h0000_0001);
        apb_transfer(1'b0, `NV12_REG_CTRL, '0);
        apb_transfer(1'b0, 4'h6, '0);
        apb_transfer(1'b1, 4'hA, 32'hdead_beef);
        repeat (2) @(negedge clk);
        video_on = 1'b1;

        for (int f = 0; f < FRAMES; f++) drive_frame(f);
        repeat (4) @(negedge clk);

        $display("Errors: %0d, luma words: %0d, chroma words: %0d", errors, y_cnt, uv_cnt);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired before the stimulus finished");
        $display("Simulation failed");
        $finish;
    end

endmodule

/* hw/nv12_top.sv */
`timescale 1ns/1ps

module nv12_top (
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  logic                        i_vsync,
    input  logic                        i_hsync,
    input  nv12_video_pkg::sample_t     i_data,
    input  nv12_apb_pkg::apb_req_t      i_apb,
    output logic [31:0]                 o_prdata,
    output logic                        o_pready,
    output logic                        o_pslverr,
    output nv12_video_pkg::plane_desc_t o_plane,
    output logic                        o_wr_start,
    output logic [15:0]                 o_y_data,
    output logic                        o_y_vld,
    output nv12_video_pkg::uv_word_u    o_uv_data,
    output logic                        o_uv_vld,
    output logic [1:0]                  o_frame_idx
);
    import nv12_video_pkg::*;
    import nv12_apb_pkg::*;

    nv12_cfg_t     cfg;
    raster_phase_t phase;

    nv12_apb_regs u_regs (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_apb     (i_apb),
        .o_prdata  (o_prdata),
        .o_pready  (o_pready),
        .o_pslverr (o_pslverr),
        .o_cfg     (cfg)
    );

    nv12_raster_ctrl u_ctrl (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_vsync     (i_vsync),
        .i_hsync     (i_hsync),
        .i_cfg       (cfg),
        .o_phase     (phase),
        .o_plane     (o_plane),
        .o_wr_start  (o_wr_start),
        .o_frame_idx (o_frame_idx)
    );

    nv12_luma_pack u_luma (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_data   (i_data),
        .i_phase  (phase),
        .o_y_data (o_y_data),
        .o_y_vld  (o_y_vld)
    );

    nv12_chroma_sub u_chroma (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_data    (i_data),
        .i_phase   (phase),
        .i_nv21    (cfg.nv21),
        .o_uv_data (o_uv_data),
        .o_uv_vld  (o_uv_vld)
    );

endmodule

/* hw/nv12_chroma_sub.sv */
`timescale 1ns/1ps
`include "nv12_defs.svh"

module nv12_chroma_sub (
    input  logic                          i_clk,
    input  logic                          i_rst_n,
    input  nv12_video_pkg::sample_t       i_data,
    input  nv12_video_pkg::raster_phase_t i_phase,
    input  logic                          i_nv21,
    output nv12_video_pkg::uv_word_u      o_uv_data,
    output logic                          o_uv_vld
);
    import nv12_video_pkg::*;

    // U and V of every chroma column
    localparam int LB_DEPTH = `NV12_IMG_W;
    localparam int LB_AW    = $clog2(LB_DEPTH);

    sample_t          line_buf [LB_DEPTH];
    logic [LB_AW-1:0] lb_idx;
    sample_t          prev;
    logic [8:0]       sum;
    sample_t          avg_q;
    logic             avg_vld;
    logic             avg_is_v;
    sample_t          u_hold;
    uv_word_u         uv_q;

    assign lb_idx = {i_phase.col, i_phase.is_v};
    assign prev   = line_buf[lb_idx];

    // ------------------------------
    // Even line store
    // ------------------------------
    always_ff @(posedge i_clk) begin
        if (i_phase.c_en && !i_phase.odd_line) begin
            line_buf[lb_idx] <= i_data;
        end
    end

    // ------------------------------
    // Vertical average
    // ------------------------------
    // Extra bit keeps the carry before halving
    assign sum = {1'b0, i_data} + {1'b0, prev};

    always_ff @(posedge i_clk) begin
        if (i_phase.c_en && i_phase.odd_line) begin
            avg_q <= sum[8:1];
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            avg_vld  <= 1'b0;
            avg_is_v <= 1'b0;
        end else begin
            avg_vld  <= i_phase.c_en && i_phase.odd_line;
            avg_is_v <= i_phase.is_v;
        end
    end

    // ------------------------------
    // U/V word packing
    // ------------------------------
    always_ff @(posedge i_clk) begin
        if (avg_vld && !avg_is_v) begin
            u_hold <= avg_q;
        end
    end

    // V completes the word, in the order the format asks for
    always_ff @(posedge i_clk) begin
        if (avg_vld && avg_is_v) begin
            if (i_nv21) begin
                uv_q.nv21.u <= u_hold;
                uv_q.nv21.v <= avg_q;
            end else begin
                uv_q.nv12.u <= u_hold;
                uv_q.nv12.v <= avg_q;
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_uv_vld <= 1'b0;
        end else begin
            o_uv_vld <= avg_vld && avg_is_v;
        end
    end

    assign o_uv_data = uv_q;

    // Even lines only fill the buffer
    a_no_even_output : assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        (i_phase.c_en && !i_phase.odd_line) |=> !o_uv_vld ##1 !o_uv_vld
    );

endmodule

/* hw/nv12_luma_pack.sv */
`timescale 1ns/1ps

module nv12_luma_pack (
    input  logic                          i_clk,
    input  logic                          i_rst_n,
    input  nv12_video_pkg::sample_t       i_data,
    input  nv12_video_pkg::raster_phase_t i_phase,
    output logic [15:0]                   o_y_data,
    output logic                          o_y_vld
);
    import nv12_video_pkg::*;

    sample_t y_first;

    // First Y of each pair waits for its partner
    always_ff @(posedge i_clk) begin
        if (i_phase.y_en && !i_phase.is_v) begin
            y_first <= i_data;
        end
    end

    // Earlier sample goes to the low byte
    always_ff @(posedge i_clk) begin
        if (i_phase.y_en && i_phase.is_v) begin
            o_y_data <= {i_data, y_first};
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_y_vld <= 1'b0;
        end else begin
            o_y_vld <= i_phase.y_en && i_phase.is_v;
        end
    end

    // Pairs are four samples apart
    a_y_vld_spacing : assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_y_vld |=> !o_y_vld
    );

endmodule

/* hw/nv12_raster_ctrl.sv */
`timescale 1ns/1ps
`include "nv12_defs.svh"

module nv12_raster_ctrl (
    input  logic                          i_clk,
    input  logic                          i_rst_n,
    input  logic                          i_vsync,
    input  logic                          i_hsync,
    input  nv12_apb_pkg::nv12_cfg_t       i_cfg,
    output nv12_video_pkg::raster_phase_t o_phase,
    output nv12_video_pkg::plane_desc_t   o_plane,
    output logic                          o_wr_start,
    output logic [1:0]                    o_frame_idx
);
    import nv12_video_pkg::*;

    localparam int HCNT_W    = $clog2(`NV12_LINE_CLKS);
    localparam int VCNT_W    = $clog2(`NV12_IMG_H);
    localparam int START_END = `NV12_START_DELAY + `NV12_START_LEN;
    localparam int TMR_W     = $clog2(START_END);

    logic [HCNT_W-1:0] hcnt;
    logic [VCNT_W-1:0] vcnt;
    logic              active;
    logic              vsync_q;
    logic              vsync_q2;
    logic              vsync_fall;
    logic [TMR_W-1:0]  tmr;
    logic [31:0]       base;
    raster_phase_t     phase;
    plane_desc_t       plane_q;

    assign active = i_vsync && i_hsync;

    // ------------------------------
    // Raster counters
    // ------------------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            hcnt <= '0;
            vcnt <= '0;
        end else if (!i_vsync) begin
            hcnt <= '0;
            vcnt <= '0;
        end else if (i_hsync) begin
            if (hcnt == HCNT_W'(`NV12_LINE_CLKS - 1)) begin
                hcnt <= '0;
                vcnt <= vcnt + 1'b1;
            end else begin
                hcnt <= hcnt + 1'b1;
            end
        end else begin
            hcnt <= '0;
        end
    end

    // Sample order inside a line is Y U Y V
    always_comb begin
        phase.y_en     = active && !hcnt[0];
        phase.c_en     = active && hcnt[0];
        phase.is_v     = hcnt[1];
        phase.odd_line = vcnt[0];
        phase.col      = hcnt[HCNT_W-1:2];
    end

    assign o_phase = phase;

    // ------------------------------
    // Frame index
    // ------------------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            vsync_q  <= 1'b0;
            vsync_q2 <= 1'b0;
        end else begin
            vsync_q  <= i_vsync;
            vsync_q2 <= vsync_q;
        end
    end

    assign vsync_fall = vsync_q2 && !vsync_q;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_frame_idx <= 2'd0;
        end else if (vsync_fall) begin
            o_frame_idx <= (o_frame_idx == 2'd2) ? 2'd0 : o_frame_idx + 2'd1;
        end
    end

    always_comb begin
        case (o_frame_idx)
            2'd0:    base = i_cfg.base0;
            2'd1:    base = i_cfg.base1;
            default: base = i_cfg.base2;
        endcase
    end

    // UV plane sits right after the Y plane
    always_ff @(posedge i_clk) begin
        plane_q.y_addr  <= base;
        plane_q.uv_addr <= base + 32'(`NV12_Y_BYTES / 4);
        plane_q.y_len   <= 32'(`NV12_Y_BYTES / 2);
        plane_q.uv_len  <= 32'(`NV12_UV_BYTES / 2);
    end

    assign o_plane = plane_q;

    // ------------------------------
    // Write start pulse
    // ------------------------------
    // Timer restarts on every vsync rise and parks at the end
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            tmr <= '0;
        end else if (!vsync_q) begin
            tmr <= '0;
        end else if (tmr != TMR_W'(START_END - 1)) begin
            tmr <= tmr + 1'b1;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_wr_start <= 1'b0;
        end else begin
            o_wr_start <= vsync_q && (tmr >= TMR_W'(`NV12_START_DELAY - 1))
                          && (tmr < TMR_W'(START_END - 1));
        end
    end

    a_frame_idx_range : assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_frame_idx != 2'd3
    );

endmodule

/* hw/nv12_apb_regs.sv */
`timescale 1ns/1ps
`include "nv12_defs.svh"

module nv12_apb_regs (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  nv12_apb_pkg::apb_req_t i_apb,
    output logic [31:0]            o_prdata,
    output logic                   o_pready,
    output logic                   o_pslverr,
    output nv12_apb_pkg::nv12_cfg_t o_cfg
);
    import nv12_apb_pkg::*;

    nv12_cfg_t   cfg_q;
    logic        access;
    logic        mapped;
    logic [31:0] rd_data;

    // Second cycle of a transfer
    assign access = i_apb.psel && i_apb.penable;

    // ------------------------------
    // Offset decode
    // ------------------------------
    always_comb begin
        mapped  = 1'b1;
        rd_data = '0;
        case (i_apb.paddr)
            `NV12_REG_ADDR0: rd_data = cfg_q.base0;
            `NV12_REG_ADDR1: rd_data = cfg_q.base1;
            `NV12_REG_ADDR2: rd_data = cfg_q.base2;
            `NV12_REG_CTRL:  rd_data = {31'd0, cfg_q.nv21};
            default:         mapped  = 1'b0;
        endcase
    end

    // Write lands at the end of the access phase
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            cfg_q <= '0;
        end else if (access && i_apb.pwrite && mapped) begin
            case (i_apb.paddr)
                `NV12_REG_ADDR0: cfg_q.base0 <= i_apb.pwdata;
                `NV12_REG_ADDR1: cfg_q.base1 <= i_apb.pwdata;
                `NV12_REG_ADDR2: cfg_q.base2 <= i_apb.pwdata;
                default:         cfg_q.nv21  <= i_apb.pwdata[0];
            endcase
        end
    end

    // No wait states
    assign o_pready  = 1'b1;
    assign o_prdata  = access ? rd_data : 32'd0;
    assign o_pslverr = access && !mapped;
    assign o_cfg     = cfg_q;

    // Access phase must follow a setup phase
    a_apb_setup_first : assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        access |-> $past(i_apb.psel && !i_apb.penable)
    );

endmodule

/* hw/nv12_apb_pkg.sv */
package nv12_apb_pkg;

    // APB request from the bus master
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [3:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    // Frame store setup held in the register file
    typedef struct packed {
        logic [31:0] base0;
        logic [31:0] base1;
        logic [31:0] base2;
        // 1 selects V before U in the chroma word
        logic        nv21;
    } nv12_cfg_t;

endpackage

/* hw/nv12_video_pkg.sv */
`include "nv12_defs.svh"

package nv12_video_pkg;

    typedef logic [`NV12_DATA_W-1:0] sample_t;

    // Per-cycle meaning of the incoming byte
    typedef struct packed {
        logic                                y_en;
        logic                                c_en;
        // Upper half of a Y U Y V group, so V for chroma and second Y for luma
        logic                                is_v;
        logic                                odd_line;
        logic [$clog2(`NV12_IMG_W / 2)-1:0] col;
    } raster_phase_t;

    typedef struct packed {
        sample_t u;
        sample_t v;
    } nv12_pair_t;

    typedef struct packed {
        sample_t v;
        sample_t u;
    } nv21_pair_t;

    // One chroma word, byte order picked by the output format
    typedef union packed {
        nv12_pair_t nv12;
        nv21_pair_t nv21;
    } uv_word_u;

    // Addresses in 32-bit words, lengths in 16-bit words
    typedef struct packed {
        logic [31:0] y_addr;
        logic [31:0] uv_addr;
        logic [31:0] y_len;
        logic [31:0] uv_len;
    } plane_desc_t;

endpackage

/* hw/nv12_defs.svh */
`ifndef NV12_DEFS_SVH
`define NV12_DEFS_SVH

// ------------------------------
// Image geometry
// ------------------------------
`define NV12_DATA_W      8
`define NV12_IMG_W       16
`define NV12_IMG_H       8
// Interleaved Y U Y V, two samples per pixel
`define NV12_LINE_CLKS   (2 * `NV12_IMG_W)
`define NV12_Y_BYTES     (`NV12_IMG_W * `NV12_IMG_H)
`define NV12_UV_BYTES    (`NV12_Y_BYTES / 2)

// Write start pulse after vsync rise
`define NV12_START_DELAY 32
`define NV12_START_LEN   9

// ------------------------------
// APB register offsets
// ------------------------------
`define NV12_REG_ADDR0   4'h0
`define NV12_REG_ADDR1   4'h4
`define NV12_REG_ADDR2   4'h8
`define NV12_REG_CTRL    4'hC

`endif
